// File: letc_core_control.f
rtl/riscv_pkg.sv
rtl/letc_core_pkg.sv
rtl/letc_core_forwarding_factory.sv
rtl/letc_core_bubble_wrap.sv
rtl/letc_core_adhesive.sv
rtl/letc_core_pc_gen.sv
rtl/letc_core_control.sv
verif/letc_core_control_tb.sv

// File: rtl/letc_core_adhesive.sv
// Adhesive glue combining forwarding, bubbles, branch flush and the fetch PC redirect
`timescale 1ns/100ps

module letc_core_adhesive
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    // Kept for parity with the stage blocks, no state lives here
    input   logic           clk,
    input   logic           rst_n,

    input   stage_mask_t    stage_ready,
    output  stage_mask_t    stage_flush,
    output  stage_mask_t    stage_stall,

    // Branch resolution from M1
    input   logic           branch_taken,
    input   pc_t            branch_target,

    // Redirect toward the fetch PC
    output  logic           pc_load_en,
    output  pc_t            pc_load_val,

    // Forwarders
    input   reg_idx_t       m1_rd_idx,
    input   logic           m1_rd_we,
    input   logic           m1_rd_val_valid,
    input   word_t          m1_rd_val,
    input   reg_idx_t       m2_rd_idx,
    input   logic           m2_rd_we,
    input   logic           m2_rd_val_valid,
    input   word_t          m2_rd_val,
    input   reg_idx_t       w_rd_idx,
    input   logic           w_rd_we,
    input   logic           w_rd_val_valid,
    input   word_t          w_rd_val,

    // Forwardees
    input   reg_idx_t       e_rs1_idx,
    input   reg_idx_t       e_rs2_idx,
    input   reg_idx_t       m1_rs2_idx,
    input   reg_idx_t       m2_rs2_idx,
    output  logic           e_rs1_use_fwd,
    output  word_t          e_rs1_fwd_val,
    output  logic           e_rs2_use_fwd,
    output  word_t          e_rs2_fwd_val,
    output  logic           m1_rs2_use_fwd,
    output  word_t          m1_rs2_fwd_val,
    output  logic           m2_rs2_use_fwd,
    output  word_t          m2_rs2_fwd_val
);

stage_mask_t    stage_hazard;
stage_mask_t    stall_mask;
stage_mask_t    bubble_mask;
logic           branch_accept;

// Operand selection and in-flight hazards
letc_core_forwarding_factory fwd_factory (.*);

// Stall prefix and the bubble behind it
letc_core_bubble_wrap bubbles (.*);

// A held M1 keeps its branch and presents it again once it moves
assign branch_accept = branch_taken && !stall_mask[stage_m1];

// Wrong-path stages behind M1 get squashed on top of any bubble
assign stage_flush = bubble_mask | (branch_accept ? branch_flush_mask : '0);

// Flush wins, a stage never sees both in one cycle
assign stage_stall = stall_mask & ~stage_flush;

assign pc_load_en  = branch_accept;
assign pc_load_val = branch_target;

endmodule : letc_core_adhesive

// File: rtl/letc_core_bubble_wrap.sv
// Bubble wrap turning blocked stages into a prefix stall and a single bubble behind it
`timescale 1ns/100ps

module letc_core_bubble_wrap
    import letc_core_pkg::*;
(
    // Per-stage readiness from the datapaths
    input   stage_mask_t    stage_ready,
    // Per-stage operand hazards from the forwarding factory
    input   stage_mask_t    stage_hazard,

    // Stages that must hold their contents this cycle
    output  stage_mask_t    stall_mask,
    // Stage that receives a bubble because the stage before it holds
    output  stage_mask_t    bubble_mask
);

// A stage is blocked by its own datapath or by an operand still in flight
stage_mask_t blocked;

assign blocked = ~stage_ready | stage_hazard;

// Stall reaches back from the furthest blocked stage k to F1
// Bit i holds when any stage at i or beyond it is blocked
// Stages past k keep moving, they have nothing in front of them to wait for
always_comb begin
    stall_mask = '0;
    for (int i = 0; i < num_stages; i++) begin
        stall_mask[i] = |(blocked >> i);
    end
end

// The stage right after k moves on but gets nothing from k
// That is the one edge where a stalled stage sits behind a moving one
// F1 has no stage before it and never takes a bubble
// When W itself is blocked the edge falls off the end of the pipe
always_comb begin
    bubble_mask = '0;
    for (int i = 1; i < num_stages; i++) begin
        bubble_mask[i] = stall_mask[i-1] & ~stall_mask[i];
    end
end

endmodule : letc_core_bubble_wrap

// File: rtl/letc_core_control.sv
// Core control top joining the adhesive glue block and the fetch PC generator
`timescale 1ns/100ps

module letc_core_control
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    input   logic           clk,
    input   logic           rst_n,

    // Pipeline handshake with the stage datapaths
    input   stage_mask_t    stage_ready,
    output  stage_mask_t    stage_stall,
    output  stage_mask_t    stage_flush,

    // Branch outcome from M1
    input   logic           branch_taken,
    input   pc_t            branch_target,

    output  pc_t            fetch_pc,

    // Forwarders
    input   reg_idx_t       m1_rd_idx,
    input   logic           m1_rd_we,
    input   logic           m1_rd_val_valid,
    input   word_t          m1_rd_val,
    input   reg_idx_t       m2_rd_idx,
    input   logic           m2_rd_we,
    input   logic           m2_rd_val_valid,
    input   word_t          m2_rd_val,
    input   reg_idx_t       w_rd_idx,
    input   logic           w_rd_we,
    input   logic           w_rd_val_valid,
    input   word_t          w_rd_val,

    // Forwardees
    input   reg_idx_t       e_rs1_idx,
    input   reg_idx_t       e_rs2_idx,
    input   reg_idx_t       m1_rs2_idx,
    input   reg_idx_t       m2_rs2_idx,
    output  logic           e_rs1_use_fwd,
    output  word_t          e_rs1_fwd_val,
    output  logic           e_rs2_use_fwd,
    output  word_t          e_rs2_fwd_val,
    output  logic           m1_rs2_use_fwd,
    output  word_t          m1_rs2_fwd_val,
    output  logic           m2_rs2_use_fwd,
    output  word_t          m2_rs2_fwd_val
);

// Redirect between glue and PC register
logic   pc_load_en;
pc_t    pc_load_val;

// Hazards, flush and redirect
letc_core_adhesive adhesive_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .stage_ready     (stage_ready),
    .stage_flush     (stage_flush),
    .stage_stall     (stage_stall),
    .branch_taken    (branch_taken),
    .branch_target   (branch_target),
    .pc_load_en      (pc_load_en),
    .pc_load_val     (pc_load_val),
    .m1_rd_idx       (m1_rd_idx),
    .m1_rd_we        (m1_rd_we),
    .m1_rd_val_valid (m1_rd_val_valid),
    .m1_rd_val       (m1_rd_val),
    .m2_rd_idx       (m2_rd_idx),
    .m2_rd_we        (m2_rd_we),
    .m2_rd_val_valid (m2_rd_val_valid),
    .m2_rd_val       (m2_rd_val),
    .w_rd_idx        (w_rd_idx),
    .w_rd_we         (w_rd_we),
    .w_rd_val_valid  (w_rd_val_valid),
    .w_rd_val        (w_rd_val),
    .e_rs1_idx       (e_rs1_idx),
    .e_rs2_idx       (e_rs2_idx),
    .m1_rs2_idx      (m1_rs2_idx),
    .m2_rs2_idx      (m2_rs2_idx),
    .e_rs1_use_fwd   (e_rs1_use_fwd),
    .e_rs1_fwd_val   (e_rs1_fwd_val),
    .e_rs2_use_fwd   (e_rs2_use_fwd),
    .e_rs2_fwd_val   (e_rs2_fwd_val),
    .m1_rs2_use_fwd  (m1_rs2_use_fwd),
    .m1_rs2_fwd_val  (m1_rs2_fwd_val),
    .m2_rs2_use_fwd  (m2_rs2_use_fwd),
    .m2_rs2_fwd_val  (m2_rs2_fwd_val)
);

// Fetch PC follows the F1 stall bit after flush has had its say
letc_core_pc_gen pc_gen_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .f1_stall    (stage_stall[stage_f1]),
    .pc_load_en  (pc_load_en),
    .pc_load_val (pc_load_val),
    .fetch_pc    (fetch_pc)
);

endmodule : letc_core_control

// File: rtl/letc_core_forwarding_factory.sv
// Forwarding factory picking the youngest in-flight result for each source operand request
`timescale 1ns/100ps

module letc_core_forwarding_factory
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    // Producers, nearest to the front of the pipe first
    input   reg_idx_t       m1_rd_idx,
    input   logic           m1_rd_we,
    input   logic           m1_rd_val_valid,
    input   word_t          m1_rd_val,
    input   reg_idx_t       m2_rd_idx,
    input   logic           m2_rd_we,
    input   logic           m2_rd_val_valid,
    input   word_t          m2_rd_val,
    input   reg_idx_t       w_rd_idx,
    input   logic           w_rd_we,
    input   logic           w_rd_val_valid,
    input   word_t          w_rd_val,

    // Consumer requests
    input   reg_idx_t       e_rs1_idx,
    input   reg_idx_t       e_rs2_idx,
    input   reg_idx_t       m1_rs2_idx,
    input   reg_idx_t       m2_rs2_idx,

    output  logic           e_rs1_use_fwd,
    output  word_t          e_rs1_fwd_val,
    output  logic           e_rs2_use_fwd,
    output  word_t          e_rs2_fwd_val,
    output  logic           m1_rs2_use_fwd,
    output  word_t          m1_rs2_fwd_val,
    output  logic           m2_rs2_use_fwd,
    output  word_t          m2_rs2_fwd_val,

    // Requester stages waiting on a result that is not computed yet
    output  stage_mask_t    stage_hazard
);

// Producers as arrays, slot s lives in stage stage_m1 + s
reg_idx_t   src_idx     [num_forwarders];
logic       src_we      [num_forwarders];
logic       src_valid   [num_forwarders];
word_t      src_val     [num_forwarders];

// Requests in port order, each tagged with the stage it sits in
localparam int req_stage [num_forwardees] = '{stage_e, stage_e, stage_m1, stage_m2};
reg_idx_t   req_idx     [num_forwardees];
logic       req_use     [num_forwardees];
logic       req_ready   [num_forwardees];
word_t      req_val     [num_forwardees];

always_comb begin
    src_idx[0]   = m1_rd_idx;
    src_we[0]    = m1_rd_we;
    src_valid[0] = m1_rd_val_valid;
    src_val[0]   = m1_rd_val;
    src_idx[1]   = m2_rd_idx;
    src_we[1]    = m2_rd_we;
    src_valid[1] = m2_rd_val_valid;
    src_val[1]   = m2_rd_val;
    src_idx[2]   = w_rd_idx;
    src_we[2]    = w_rd_we;
    src_valid[2] = w_rd_val_valid;
    src_val[2]   = w_rd_val;
end

always_comb begin
    req_idx[0]   = e_rs1_idx;
    req_idx[1]   = e_rs2_idx;
    req_idx[2]   = m1_rs2_idx;
    req_idx[3]   = m2_rs2_idx;
end

// Priority match per request
always_comb begin
    stage_hazard = '0;
    for (int r = 0; r < num_forwardees; r++) begin
        req_use[r]   = 1'b0;
        req_ready[r] = 1'b1;
        req_val[r]   = '0;
        // Walk from W toward M1 so the nearest producer overwrites older matches
        for (int s = num_forwarders - 1; s >= 0; s--) begin
            // Only producers further down the pipe than the requester qualify
            if ((stage_m1 + s > req_stage[r]) && src_we[s] &&
                (src_idx[s] == req_idx[r]) && (req_idx[r] != reg_zero)) begin
                req_use[r]   = 1'b1;
                req_ready[r] = src_valid[s];
                req_val[r]   = src_val[s];
            end
        end
        // Winner has no value yet, so the requester has to wait for it
        if (req_use[r] && !req_ready[r]) begin
            stage_hazard[req_stage[r]] = 1'b1;
        end
    end
end

assign e_rs1_use_fwd  = req_use[0];
assign e_rs1_fwd_val  = req_val[0];
assign e_rs2_use_fwd  = req_use[1];
assign e_rs2_fwd_val  = req_val[1];
assign m1_rs2_use_fwd = req_use[2];
assign m1_rs2_fwd_val = req_val[2];
assign m2_rs2_use_fwd = req_use[3];
assign m2_rs2_fwd_val = req_val[3];

endmodule : letc_core_forwarding_factory

// File: rtl/letc_core_pc_gen.sv
// Fetch PC generator that redirects, advances or holds the fetch address
`timescale 1ns/100ps

module letc_core_pc_gen
    import letc_core_pkg::*;
(
    input   logic   clk,
    input   logic   rst_n,

    // F1 held by the stall prefix
    input   logic   f1_stall,

    // Redirect from the adhesive block
    input   logic   pc_load_en,
    input   pc_t    pc_load_val,

    output  pc_t    fetch_pc
);

pc_t next_pc;

// Redirect beats sequential advance, advance beats hold
always_comb begin
    if (pc_load_en) begin
        next_pc = pc_load_val;
    end else if (!f1_stall) begin
        next_pc = fetch_pc + pc_step;
    end else begin
        next_pc = fetch_pc;
    end
end

// Fetch address register
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        fetch_pc <= reset_pc;
    end else begin
        fetch_pc <= next_pc;
    end
end

endmodule : letc_core_pc_gen

// File: rtl/letc_core_pkg.sv
// Core pipeline package with stage indices, stage masks and fetch PC constants

package letc_core_pkg;

// Seven stages in program order
// F1 F2 D E M1 M2 W
localparam int num_stages = 7;

// Stage indices, also the bit position of each stage in any stage mask
localparam int stage_f1 = 0;
localparam int stage_f2 = 1;
localparam int stage_d  = 2;
localparam int stage_e  = 3;
localparam int stage_m1 = 4;
localparam int stage_m2 = 5;
localparam int stage_w  = 6;

// Result producers are M1, M2 and W, in that order
localparam int num_forwarders = 3;

// Operand consumers are E rs1, E rs2, M1 rs2 and M2 rs2
localparam int num_forwardees = 4;

// One bit per stage
typedef logic [num_stages-1:0] stage_mask_t;

// Fetch address
typedef logic [31:0] pc_t;

// Fetch starts at address zero out of reset
localparam pc_t reset_pc = 32'h0000_0000;

// Sequential fetch, one 32-bit instruction per cycle
localparam pc_t pc_step = 32'd4;

// Branches resolve in M1, so everything younger than M1 is on the wrong path
localparam stage_mask_t branch_flush_mask = stage_mask_t'(
    (1 << stage_f1) | (1 << stage_f2) | (1 << stage_d) | (1 << stage_e)
);

endpackage : letc_core_pkg

// File: rtl/riscv_pkg.sv
// RISC-V ISA package with register index and data word types shared by the core

package riscv_pkg;

// Architectural data width for RV32
localparam int xlen = 32;

// Number of bits needed to name one of the 32 integer registers
localparam int reg_idx_width = 5;

// Register index as it appears in rs1, rs2 and rd fields
typedef logic [reg_idx_width-1:0] reg_idx_t;

// Hardwired zero register, never a real producer or consumer of data
localparam reg_idx_t reg_zero = reg_idx_t'(0);

// One integer data word
typedef logic [xlen-1:0] word_t;

endpackage : riscv_pkg

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the control testbench with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module letc_core_control_tb -f letc_core_control.f \
    -Mdir "$build_dir" -o sim_bin
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$build_dir/sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "CHECKS FAILED" "$log_file"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: verif/letc_core_control_tb.sv
// Control testbench driving random pipeline traffic against a rule-based reference model
`timescale 1ns/100ps

module letc_core_control_tb
    import riscv_pkg::*;
    import letc_core_pkg::*;
();

// Run length, the timeout sits a little past the last driven cycle
localparam int reset_cycles   = 16;
localparam int quiet_cycles   = 4;
localparam int random_cycles  = 2000;
localparam int timeout_cycles = reset_cycles + quiet_cycles + random_cycles + 80;

logic           clk = 1'b0;
logic           rst_n;
stage_mask_t    stage_ready, stage_stall, stage_flush;
logic           branch_taken;
pc_t            branch_target, fetch_pc;
reg_idx_t       m1_rd_idx, m2_rd_idx, w_rd_idx;
logic           m1_rd_we, m2_rd_we, w_rd_we;
logic           m1_rd_val_valid, m2_rd_val_valid, w_rd_val_valid;
word_t          m1_rd_val, m2_rd_val, w_rd_val;
reg_idx_t       e_rs1_idx, e_rs2_idx, m1_rs2_idx, m2_rs2_idx;
logic           e_rs1_use_fwd, e_rs2_use_fwd, m1_rs2_use_fwd, m2_rs2_use_fwd;
word_t          e_rs1_fwd_val, e_rs2_fwd_val, m1_rs2_fwd_val, m2_rs2_fwd_val;

// Reference model state, request order is E rs1, E rs2, M1 rs2, M2 rs2
logic           exp_use [4];
word_t          exp_val [4];
logic           exp_wait [4];
stage_mask_t    blocked, raw_stall, exp_stall, exp_flush;
int             last_blocked;
logic           exp_accept;
pc_t            exp_pc;

integer         seed = 32'he53b_384d;
int             cycle_count = 0;

letc_core_control letc_core_control_inst (.*);

// 40 ns clock
always #20 clk = ~clk;

task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    report_failure($sformatf("MISMATCH %s dut=%h expected=%h", name, got, exp));
endtask

// Nearest matching producer that sits further down the pipe than the requester
function automatic void pick_producer(input reg_idx_t idx, input int req_stage,
        output logic use_fwd, output word_t val, output logic waiting);
    use_fwd = 1'b0;
    val = '0;
    waiting = 1'b0;
    if (idx != 5'd0 && req_stage < stage_m1 && m1_rd_we && m1_rd_idx == idx) begin
        use_fwd = 1'b1;
        val = m1_rd_val;
        waiting = !m1_rd_val_valid;
    end else if (idx != 5'd0 && req_stage < stage_m2 && m2_rd_we && m2_rd_idx == idx) begin
        use_fwd = 1'b1;
        val = m2_rd_val;
        waiting = !m2_rd_val_valid;
    end else if (idx != 5'd0 && req_stage < stage_w && w_rd_we && w_rd_idx == idx) begin
        use_fwd = 1'b1;
        val = w_rd_val;
        waiting = !w_rd_val_valid;
    end
endfunction

// Expected forwarding, stall prefix, bubble and branch flush
always_comb begin
    pick_producer(e_rs1_idx, stage_e, exp_use[0], exp_val[0], exp_wait[0]);
    pick_producer(e_rs2_idx, stage_e, exp_use[1], exp_val[1], exp_wait[1]);
    pick_producer(m1_rs2_idx, stage_m1, exp_use[2], exp_val[2], exp_wait[2]);
    pick_producer(m2_rs2_idx, stage_m2, exp_use[3], exp_val[3], exp_wait[3]);
    blocked = ~stage_ready;
    blocked[stage_e]  = blocked[stage_e] | exp_wait[0] | exp_wait[1];
    blocked[stage_m1] = blocked[stage_m1] | exp_wait[2];
    blocked[stage_m2] = blocked[stage_m2] | exp_wait[3];
    // Highest blocked stage decides
    last_blocked = -1;
    for (int i = 0; i < num_stages; i++) begin
        if (blocked[i]) last_blocked = i;
    end
    exp_flush = '0;
    for (int i = 0; i < num_stages; i++) begin
        raw_stall[i] = (i <= last_blocked);
    end
    if (last_blocked >= 0 && last_blocked + 1 < num_stages) begin
        exp_flush[last_blocked + 1] = 1'b1;
    end
    exp_accept = branch_taken && !raw_stall[stage_m1];
    if (exp_accept) exp_flush = exp_flush | branch_flush_mask;
    exp_stall = raw_stall & ~exp_flush;
end

// Expected fetch PC, redirect first, then advance, else hold
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        exp_pc <= reset_pc;
    end else if (exp_accept) begin
        exp_pc <= branch_target;
    end else if (!exp_stall[stage_f1]) begin
        exp_pc <= exp_pc + pc_step;
    end
end

a_reset_pc: assert property (@(posedge clk) !rst_n |-> fetch_pc == reset_pc)
    else report_mismatch("fetch_pc", $sampled(fetch_pc), reset_pc);
a_fetch_pc: assert property (@(posedge clk) fetch_pc == exp_pc)
    else report_mismatch("fetch_pc", $sampled(fetch_pc), $sampled(exp_pc));
a_stall: assert property (@(posedge clk) stage_stall == exp_stall)
    else report_mismatch("stage_stall", 32'($sampled(stage_stall)), 32'($sampled(exp_stall)));
a_flush: assert property (@(posedge clk) stage_flush == exp_flush)
    else report_mismatch("stage_flush", 32'($sampled(stage_flush)), 32'($sampled(exp_flush)));
a_excl: assert property (@(posedge clk) (stage_stall & stage_flush) == '0)
    else report_failure("A stage shows stall and flush in the same cycle");
a_e_rs1_use: assert property (@(posedge clk) e_rs1_use_fwd == exp_use[0])
    else report_mismatch("e_rs1_use_fwd", 32'($sampled(e_rs1_use_fwd)), 32'($sampled(exp_use[0])));
a_e_rs1_val: assert property (@(posedge clk) e_rs1_fwd_val == exp_val[0])
    else report_mismatch("e_rs1_fwd_val", $sampled(e_rs1_fwd_val), $sampled(exp_val[0]));
a_e_rs2_use: assert property (@(posedge clk) e_rs2_use_fwd == exp_use[1])
    else report_mismatch("e_rs2_use_fwd", 32'($sampled(e_rs2_use_fwd)), 32'($sampled(exp_use[1])));
a_e_rs2_val: assert property (@(posedge clk) e_rs2_fwd_val == exp_val[1])
    else report_mismatch("e_rs2_fwd_val", $sampled(e_rs2_fwd_val), $sampled(exp_val[1]));
a_m1_rs2_use: assert property (@(posedge clk) m1_rs2_use_fwd == exp_use[2])
    else report_mismatch("m1_rs2_use_fwd", 32'($sampled(m1_rs2_use_fwd)), 32'($sampled(exp_use[2])));
a_m1_rs2_val: assert property (@(posedge clk) m1_rs2_fwd_val == exp_val[2])
    else report_mismatch("m1_rs2_fwd_val", $sampled(m1_rs2_fwd_val), $sampled(exp_val[2]));
a_m2_rs2_use: assert property (@(posedge clk) m2_rs2_use_fwd == exp_use[3])
    else report_mismatch("m2_rs2_use_fwd", 32'($sampled(m2_rs2_use_fwd)), 32'($sampled(exp_use[3])));
a_m2_rs2_val: assert property (@(posedge clk) m2_rs2_fwd_val == exp_val[3])
    else report_mismatch("m2_rs2_fwd_val", $sampled(m2_rs2_fwd_val), $sampled(exp_val[3]));

// Small index range keeps matches and x0 requests frequent
function automatic reg_idx_t rand_idx();
    logic [31:0] r;
    r = $random(seed);
    return reg_idx_t'(r[1:0]);
endfunction

function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
endfunction

task automatic drive_random_inputs();
    logic [31:0] r;
    stage_mask_t ready_next;
    // Each stage not ready about one cycle in eight
    for (int i = 0; i < num_stages; i++) begin
        r = $random(seed);
        ready_next[i] = (r[2:0] != 3'd0);
    end
    r = $random(seed);
    stage_ready     <= ready_next;
    branch_taken    <= ((r % 32'd6) == 32'd0);
    branch_target   <= $random(seed);
    m1_rd_idx       <= rand_idx();
    m1_rd_we        <= rand_bit();
    m1_rd_val_valid <= rand_bit();
    m1_rd_val       <= $random(seed);
    m2_rd_idx       <= rand_idx();
    m2_rd_we        <= rand_bit();
    m2_rd_val_valid <= rand_bit();
    m2_rd_val       <= $random(seed);
    w_rd_idx        <= rand_idx();
    w_rd_we         <= rand_bit();
    w_rd_val_valid  <= rand_bit();
    w_rd_val        <= $random(seed);
    e_rs1_idx       <= rand_idx();
    e_rs2_idx       <= rand_idx();
    m1_rs2_idx      <= rand_idx();
    m2_rs2_idx      <= rand_idx();
endtask

// Guard against a run that never reaches its end
always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
        report_failure("Timeout, the test did not finish within the cycle limit");
    end
end

initial begin
    // Quiet pipe, all ready, nothing writing
    rst_n <= 1'b0;
    stage_ready <= '1;
    branch_taken <= 1'b0;
    branch_target <= '0;
    {m1_rd_idx, m2_rd_idx, w_rd_idx} <= '0;
    {m1_rd_we, m2_rd_we, w_rd_we} <= '0;
    {m1_rd_val_valid, m2_rd_val_valid, w_rd_val_valid} <= '0;
    {m1_rd_val, m2_rd_val, w_rd_val} <= '0;
    {e_rs1_idx, e_rs2_idx, m1_rs2_idx, m2_rs2_idx} <= '0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    // Free-running fetch right after reset
    repeat (quiet_cycles) @(posedge clk);
    for (int n = 0; n < random_cycles; n++) begin
        @(posedge clk);
        drive_random_inputs();
    end
    // Last vector and the fetch PC it produced are checked on these edges
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
end

endmodule : letc_core_control_tb
